// ==== uart_rx_cfg.svh ====
/*
 Default configuration macros for the UART receive peripheral:
 clock and baud rates, FIFO depth, register map and special words.
*/

`ifndef UART_RX_CFG_SVH
`define UART_RX_CFG_SVH

// Default system clock and serial rate, 16 clocks per bit.
`define UART_RX_CLOCK_HZ 1000000
`define UART_RX_BAUD_RATE 62500

// Receive FIFO depth, power of two.
`define UART_RX_FIFO_DEPTH 8

// Register map.
`define UART_RX_ADDR_DATA 2'd0
`define UART_RX_ADDR_STATUS 2'd1
`define UART_RX_ADDR_CLEAR 2'd2

// Word returned by a clear request.
`define UART_RX_CLEAR_ACK 32'hcafe_babe

// Received character that requests a soft reset.
`define UART_RX_SOFT_RESET_CHAR 8'hff

// Status word bit positions.
`define UART_RX_STATUS_OVERFLOW_BIT 0
`define UART_RX_STATUS_EMPTY_BIT 1

`endif

// ==== uart_rx_pkg.sv ====
/*
 Shared types for the UART receive peripheral:
 data and bus vectors, deframer and read controller states.
*/

`default_nettype none

package uart_rx_pkg;

	// One received character.
	typedef logic [7:0] rx_byte_t;

	// Bus register address and read data.
	typedef logic [1:0] bus_addr_t;
	typedef logic [31:0] bus_word_t;

	// Serial frame states.
	typedef enum logic [1:0] {
		FRAME_IDLE,
		FRAME_START,
		FRAME_DATA,
		FRAME_STOP
	} frame_state_t;

	// Bus read sequencing.
	typedef enum logic [1:0] {
		READ_IDLE,
		READ_POP,
		READ_CAPTURE,
		READ_DONE
	} read_state_t;

endpackage

`default_nettype wire

// ==== uart_rx_deframer.sv ====
/*
 Serial deframer: line synchronizer, baud prescaler and frame FSM.
 Emits accepted bytes, the interrupt pulse and the soft-reset pulse.
*/

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_cfg.svh"

module uart_rx_deframer
	import uart_rx_pkg::*;
#(
	parameter int CLOCK_HZ = `UART_RX_CLOCK_HZ,
	parameter int BAUD_RATE = `UART_RX_BAUD_RATE
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_rx,
	output logic o_byte_valid,
	output rx_byte_t o_byte_data,
	output logic o_interrupt,
	output logic o_soft_reset
);
	localparam int BIT_CLOCKS = CLOCK_HZ / BAUD_RATE;
	localparam int HALF_CLOCKS = BIT_CLOCKS / 2;
	localparam int PRESCALE_W = $clog2(BIT_CLOCKS + 1);

	frame_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [PRESCALE_W-1:0] prescale;
	logic [2:0] bit_count;
	rx_byte_t shift_data;
	logic sample_tick;

	// Two-flop synchronizer, idles high.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	// Sample point reached once the prescaler has run down.
	assign sample_tick = (prescale == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FRAME_IDLE;
			prescale <= '0;
			bit_count <= '0;
			o_byte_valid <= 1'b0;
			o_interrupt <= 1'b0;
			o_soft_reset <= 1'b0;
		end else begin
			o_byte_valid <= 1'b0;
			o_interrupt <= 1'b0;
			o_soft_reset <= 1'b0;

			if (!sample_tick) begin
				prescale <= prescale - 1'b1;
			end

			case (state)
				FRAME_IDLE: begin
					if (!rx_sync) begin
						// Falling edge, wait for middle of start bit.
						state <= FRAME_START;
						prescale <= PRESCALE_W'(HALF_CLOCKS - 1);
					end
				end
				FRAME_START: begin
					if (sample_tick) begin
						if (!rx_sync) begin
							state <= FRAME_DATA;
							prescale <= PRESCALE_W'(BIT_CLOCKS - 1);
							bit_count <= '0;
						end else begin
							// Glitch, not a real start bit.
							state <= FRAME_IDLE;
						end
					end
				end
				FRAME_DATA: begin
					if (sample_tick) begin
						prescale <= PRESCALE_W'(BIT_CLOCKS - 1);
						bit_count <= bit_count + 1'b1;
						if (bit_count == 3'd7) begin
							state <= FRAME_STOP;
						end
					end
				end
				FRAME_STOP: begin
					if (sample_tick) begin
						state <= FRAME_IDLE;
						// A low stop bit drops the frame.
						if (rx_sync) begin
							o_byte_valid <= 1'b1;
							o_interrupt <= 1'b1;
							o_soft_reset <= (shift_data == `UART_RX_SOFT_RESET_CHAR);
						end
					end
				end
				default: begin
					state <= FRAME_IDLE;
				end
			endcase
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge i_clock) begin
		if (state == FRAME_DATA && sample_tick) begin
			shift_data <= {rx_sync, shift_data[7:1]};
		end
	end

	assign o_byte_data = shift_data;

	a_valid_single: assert property (@(posedge i_clock) disable iff (i_reset)
		o_byte_valid |=> !o_byte_valid);

	a_soft_reset_with_irq: assert property (@(posedge i_clock) disable iff (i_reset)
		o_soft_reset |-> o_interrupt && (o_byte_data == `UART_RX_SOFT_RESET_CHAR));

endmodule

`default_nettype wire

// ==== uart_rx_fifo.sv ====
/*
 Synchronous receive byte FIFO with registered read data,
 clear input and a drop pulse for pushes into a full FIFO.
*/

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_cfg.svh"

module uart_rx_fifo
	import uart_rx_pkg::*;
#(
	parameter int DEPTH = `UART_RX_FIFO_DEPTH
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_clear,
	input wire i_push,
	input wire rx_byte_t i_push_data,
	input wire i_pop,
	output rx_byte_t o_pop_data,
	output logic o_empty,
	output logic o_dropped
);
	localparam int AW = $clog2(DEPTH);

	rx_byte_t mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic full;

	// Extra pointer bit tells full from empty.
	assign o_empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign o_dropped = i_push && full;

	always_ff @(posedge i_clock) begin
		if (i_reset || i_clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_push && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_pop && !o_empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Storage and read port.
	always_ff @(posedge i_clock) begin
		if (i_push && !full) begin
			mem[wr_ptr[AW-1:0]] <= i_push_data;
		end
		if (i_pop) begin
			o_pop_data <= mem[rd_ptr[AW-1:0]];
		end
	end

	a_no_pop_empty: assert property (@(posedge i_clock) disable iff (i_reset)
		i_pop |-> !o_empty);

endmodule

`default_nettype wire

// ==== uart_rx_bus_ctrl.sv ====
/*
 Bus register controller: decodes read requests, sequences FIFO pops,
 forms status and acknowledge words and keeps the overflow flag.
*/

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_cfg.svh"

module uart_rx_bus_ctrl
	import uart_rx_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire bus_addr_t i_address,
	output bus_word_t o_rdata,
	output logic o_ready,
	output logic o_fifo_pop,
	output logic o_fifo_clear,
	input wire i_fifo_empty,
	input wire rx_byte_t i_fifo_rdata,
	input wire i_fifo_dropped
);
	read_state_t state;
	logic overflow;
	bus_word_t status_word;

	always_comb begin
		status_word = '0;
		status_word[`UART_RX_STATUS_OVERFLOW_BIT] = overflow;
		status_word[`UART_RX_STATUS_EMPTY_BIT] = i_fifo_empty;
	end

	assign o_ready = (state == READ_DONE) && i_request;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= READ_IDLE;
			o_rdata <= '0;
			o_fifo_pop <= 1'b0;
			o_fifo_clear <= 1'b0;
		end else begin
			o_fifo_pop <= 1'b0;
			o_fifo_clear <= 1'b0;

			if (!i_request) begin
				state <= READ_IDLE;
			end else begin
				case (state)
					READ_IDLE: begin
						case (i_address)
							`UART_RX_ADDR_DATA: begin
								// Wait here until a byte is queued.
								if (!i_fifo_empty) begin
									o_fifo_pop <= 1'b1;
									state <= READ_POP;
								end
							end
							`UART_RX_ADDR_STATUS: begin
								o_rdata <= status_word;
								state <= READ_DONE;
							end
							`UART_RX_ADDR_CLEAR: begin
								o_fifo_clear <= 1'b1;
								o_rdata <= `UART_RX_CLEAR_ACK;
								state <= READ_DONE;
							end
							default: begin
								o_rdata <= '0;
								state <= READ_DONE;
							end
						endcase
					end
					// FIFO registers the byte on this edge.
					READ_POP: begin
						state <= READ_CAPTURE;
					end
					READ_CAPTURE: begin
						o_rdata <= {24'b0, i_fifo_rdata};
						state <= READ_DONE;
					end
					READ_DONE: begin
						// Hold until the host drops the request.
						state <= READ_DONE;
					end
					default: begin
						state <= READ_IDLE;
					end
				endcase
			end
		end
	end

	// Sticky overflow, clear takes priority over a new drop.
	always_ff @(posedge i_clock) begin
		if (i_reset || o_fifo_clear) begin
			overflow <= 1'b0;
		end else if (i_fifo_dropped) begin
			overflow <= 1'b1;
		end
	end

	// A held request keeps the completed access steady.
	a_ready_holds_data: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |=> !i_request || (o_ready && $stable(o_rdata)));

endmodule

`default_nettype wire

// ==== uart_rx_periph.sv ====
/*
 UART receive peripheral top level.
 Connects the deframer, receive FIFO and bus register controller.
*/

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_cfg.svh"

module uart_rx_periph
	import uart_rx_pkg::*;
#(
	parameter int CLOCK_HZ = `UART_RX_CLOCK_HZ,
	parameter int BAUD_RATE = `UART_RX_BAUD_RATE,
	parameter int FIFO_DEPTH = `UART_RX_FIFO_DEPTH
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire bus_addr_t i_address,
	output bus_word_t o_rdata,
	output logic o_ready,
	output logic o_interrupt,
	output logic o_soft_reset,
	input wire i_rx
);
	logic byte_valid;
	rx_byte_t byte_data;
	logic fifo_pop;
	logic fifo_clear;
	logic fifo_empty;
	rx_byte_t fifo_rdata;
	logic fifo_dropped;

	uart_rx_deframer #(
		.CLOCK_HZ(CLOCK_HZ),
		.BAUD_RATE(BAUD_RATE)
	) u_deframer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rx(i_rx),
		.o_byte_valid(byte_valid),
		.o_byte_data(byte_data),
		.o_interrupt(o_interrupt),
		.o_soft_reset(o_soft_reset)
	);

	uart_rx_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_clear(fifo_clear),
		.i_push(byte_valid),
		.i_push_data(byte_data),
		.i_pop(fifo_pop),
		.o_pop_data(fifo_rdata),
		.o_empty(fifo_empty),
		.o_dropped(fifo_dropped)
	);

	uart_rx_bus_ctrl u_bus_ctrl (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_address(i_address),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_fifo_pop(fifo_pop),
		.o_fifo_clear(fifo_clear),
		.i_fifo_empty(fifo_empty),
		.i_fifo_rdata(fifo_rdata),
		.i_fifo_dropped(fifo_dropped)
	);

endmodule

`default_nettype wire

// ==== tb_uart_rx_periph.sv ====
/*
 Directed testbench for the UART receive peripheral.
 Serial frame driver, bus read task, LCG byte source, tests and watchdog.
*/

`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_cfg.svh"

module tb_uart_rx_periph
	import uart_rx_pkg::*;
();
	localparam int CLOCK_PERIOD_NS = 8;
	localparam int BIT_CLOCKS = `UART_RX_CLOCK_HZ / `UART_RX_BAUD_RATE;
	localparam int FRAME_CLOCKS = 10 * BIT_CLOCKS;
	localparam int FIFO_DEPTH = `UART_RX_FIFO_DEPTH;
	// Frames sent by all tests together.
	localparam int TOTAL_FRAMES = 1 + 5 + 2 + 2 + FIFO_DEPTH + 3;
	localparam int WATCHDOG_NS = 2 * TOTAL_FRAMES * FRAME_CLOCKS * CLOCK_PERIOD_NS + 20000;
	localparam int READ_TIMEOUT_CLOCKS = 64;

	logic clock;
	logic reset;
	logic request;
	bus_addr_t address;
	bus_word_t rdata;
	logic ready;
	logic interrupt;
	logic soft_reset;
	logic rx;

	int error_count = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int irq_count = 0;
	int soft_count = 0;
	int soft_expected = 0;
	logic [31:0] lcg_state;

	uart_rx_periph uut (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_address(address),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_interrupt(interrupt),
		.o_soft_reset(soft_reset),
		.i_rx(rx)
	);

	always #(CLOCK_PERIOD_NS / 2) clock = ~clock;

	// Pulse counters, sampled away from the active edge.
	always @(negedge clock) begin
		if (!reset && interrupt) begin
			irq_count = irq_count + 1;
		end
		if (!reset && soft_reset) begin
			soft_count = soft_count + 1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic next_random_byte(output rx_byte_t value);
		lcg_state = lcg_step(lcg_state);
		value = lcg_state[23:16];
	endtask

	// Status word as the register map defines it.
	function automatic bus_word_t status_word(input logic empty, input logic overflow);
		bus_word_t word;
		word = '0;
		word[`UART_RX_STATUS_EMPTY_BIT] = empty;
		word[`UART_RX_STATUS_OVERFLOW_BIT] = overflow;
		return word;
	endfunction

	task automatic expect_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("[FAIL] %0t ns: %s", $time, msg);
			test_errors++;
		end
	endtask

	task automatic expect_word(input bus_word_t actual, input bus_word_t expected,
			input string what);
		assert (actual === expected) else begin
			$display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, actual, expected);
			test_errors++;
		end
	endtask

	// Start bit, eight data bits LSB first, then the chosen stop level.
	task automatic send_frame(input rx_byte_t data, input logic stop_level);
		int i;
		rx = 1'b0;
		repeat (BIT_CLOCKS) @(negedge clock);
		for (i = 0; i < 8; i++) begin
			rx = data[i];
			repeat (BIT_CLOCKS) @(negedge clock);
		end
		rx = stop_level;
		repeat (BIT_CLOCKS) @(negedge clock);
		rx = 1'b1;
		if (stop_level && data == `UART_RX_SOFT_RESET_CHAR) begin
			soft_expected++;
		end
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_word_t value, output logic ok);
		int waited;
		address = addr;
		request = 1'b1;
		waited = 0;
		ok = 1'b0;
		value = '0;
		while (!ok && waited < READ_TIMEOUT_CLOCKS) begin
			@(negedge clock);
			waited++;
			if (ready) begin
				value = rdata;
				ok = 1'b1;
			end
		end
		request = 1'b0;
		if (!ok) begin
			$display("bus read of address %0d got no ready within %0d cycles",
				addr, READ_TIMEOUT_CLOCKS);
			test_errors++;
		end
		// Request stays low for one cycle between accesses.
		@(negedge clock);
	endtask

	task automatic read_expect(input bus_addr_t addr, input bus_word_t expected,
			input string what);
		bus_word_t value;
		logic ok;
		bus_read(addr, value, ok);
		if (ok) begin
			expect_word(value, expected, what);
		end
	endtask

	task automatic finish_test(input string name);
		expect_true(soft_count == soft_expected, "soft reset pulse count differs");
		tests_run++;
		error_count += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end else begin
			$display("test %s: ok", name);
		end
		test_errors = 0;
	endtask

	task automatic test_reset_state();
		expect_true(ready == 1'b0, "o_ready high after reset");
		expect_true(interrupt == 1'b0, "o_interrupt high after reset");
		expect_true(soft_reset == 1'b0, "o_soft_reset high after reset");
		read_expect(`UART_RX_ADDR_STATUS, status_word(1'b1, 1'b0), "status after reset");
		read_expect(2'd3, '0, "unmapped address");
		finish_test("reset_state");
	endtask

	task automatic test_single_frame();
		rx_byte_t value;
		int irq_before;
		next_random_byte(value);
		irq_before = irq_count;
		send_frame(value, 1'b1);
		expect_true(irq_count == irq_before + 1, "single frame interrupt count");
		read_expect(`UART_RX_ADDR_DATA, {24'b0, value}, "single frame data");
		read_expect(`UART_RX_ADDR_STATUS, status_word(1'b1, 1'b0), "status after data read");
		finish_test("single_frame");
	endtask

	task automatic test_burst();
		rx_byte_t sent [5];
		int irq_before;
		int i;
		irq_before = irq_count;
		for (i = 0; i < 5; i++) begin
			next_random_byte(sent[i]);
			send_frame(sent[i], 1'b1);
		end
		expect_true(irq_count == irq_before + 5, "burst interrupt count");
		for (i = 0; i < 5; i++) begin
			read_expect(`UART_RX_ADDR_DATA, {24'b0, sent[i]}, $sformatf("burst byte %0d", i));
		end
		finish_test("burst");
	endtask

	task automatic test_soft_reset();
		rx_byte_t value;
		int soft_before;
		soft_before = soft_count;
		send_frame(`UART_RX_SOFT_RESET_CHAR, 1'b1);
		expect_true(soft_count == soft_before + 1, "soft reset did not pulse once");
		read_expect(`UART_RX_ADDR_DATA, {24'b0, `UART_RX_SOFT_RESET_CHAR}, "soft reset byte");
		next_random_byte(value);
		if (value == `UART_RX_SOFT_RESET_CHAR) begin
			value = 8'h5a;
		end
		send_frame(value, 1'b1);
		expect_true(soft_count == soft_before + 1, "soft reset pulsed for another byte");
		read_expect(`UART_RX_ADDR_DATA, {24'b0, value}, "byte after soft reset");
		finish_test("soft_reset");
	endtask

	task automatic test_rejected_frames();
		rx_byte_t value;
		int irq_before;
		irq_before = irq_count;
		// Glitch of a quarter bit.
		rx = 1'b0;
		repeat (BIT_CLOCKS / 4) @(negedge clock);
		rx = 1'b1;
		repeat (BIT_CLOCKS) @(negedge clock);
		next_random_byte(value);
		send_frame(value, 1'b0);
		repeat (BIT_CLOCKS) @(negedge clock);
		expect_true(irq_count == irq_before, "rejected frame raised an interrupt");
		read_expect(`UART_RX_ADDR_STATUS, status_word(1'b1, 1'b0), "status after rejects");
		finish_test("rejected_frames");
	endtask

	task automatic test_overflow();
		rx_byte_t sent [FIFO_DEPTH + 2];
		rx_byte_t extra;
		int irq_before;
		int i;
		irq_before = irq_count;
		for (i = 0; i < FIFO_DEPTH + 2; i++) begin
			next_random_byte(sent[i]);
			send_frame(sent[i], 1'b1);
		end
		expect_true(irq_count == irq_before + FIFO_DEPTH + 2, "overflow interrupt count");
		read_expect(`UART_RX_ADDR_STATUS, status_word(1'b0, 1'b1), "status when overflowed");
		for (i = 0; i < FIFO_DEPTH; i++) begin
			read_expect(`UART_RX_ADDR_DATA, {24'b0, sent[i]}, $sformatf("kept byte %0d", i));
		end
		// One byte left queued for the clear to discard.
		next_random_byte(extra);
		send_frame(extra, 1'b1);
		read_expect(`UART_RX_ADDR_CLEAR, `UART_RX_CLEAR_ACK, "clear acknowledge");
		read_expect(`UART_RX_ADDR_STATUS, status_word(1'b1, 1'b0), "status after clear");
		finish_test("overflow");
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		request = 1'b0;
		address = '0;
		rx = 1'b1;
		lcg_state = 32'h6a56;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		test_reset_state();
		test_single_frame();
		test_burst();
		test_soft_reset();
		test_rejected_frames();
		test_overflow();

		$display("tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_rx_periph.f ====
+incdir+.
uart_rx_pkg.sv
uart_rx_deframer.sv
uart_rx_fifo.sv
uart_rx_bus_ctrl.sv
uart_rx_periph.sv
tb_uart_rx_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART receive testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f uart_rx_periph.f \
	--top-module tb_uart_rx_periph -Mdir obj_dir -o sim_uart_rx > build.log 2>&1 \
	&& ./obj_dir/sim_uart_rx > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^sim passed$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
